// ==== logic/exec_pkg.sv ====
// Fixed RV64 widths with 32 registers; opcode codes above OP_SRA are never executed.
`default_nettype none

package exec_pkg;

    // ----------------------------------------------------------------------
    // Widths.
    // ----------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int SHAMT_W    = 6;

    // Opcodes; values 10 to 15 are unused.
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLTU = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_SRA  = 4'd9
    } exec_op_e;

    // ----------------------------------------------------------------------
    // Structs passed between the blocks.
    // ----------------------------------------------------------------------

    // Command word, low 19 bits of a bus write.
    typedef struct packed {
        exec_op_e              op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } exec_cmd_t;

    typedef struct packed {
        logic                  valid;
        exec_op_e              op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } unit_result_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
// Wishbone classic with word addresses only; no select lines, err, retry or tags.
`default_nettype none

package bus_pkg;

    // ----------------------------------------------------------------------
    // Bus widths and address map.
    // ----------------------------------------------------------------------
    localparam int WB_ADR_W = 6;
    localparam int WB_DAT_W = 64;

    // Addresses 0 to 31 are x0 to x31.
    localparam logic [WB_ADR_W-1:0] ADR_CMD = 6'd32;

    // Master to slave.
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/register_file.sv ====
// One write port and two combinational reads; a read in the write cycle sees the old value.
`default_nettype none
`timescale 1ns/1ps

module register_file
    import exec_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  arstn,

    // Write port.
    input  wire reg_write_t            i_wr,

    // Read ports.
    input  wire logic [REG_ADDR_W-1:0] i_raddr_a,
    input  wire logic [REG_ADDR_W-1:0] i_raddr_b,
    output logic      [XLEN-1:0]       o_rdata_a,
    output logic      [XLEN-1:0]       o_rdata_b
);

    // ----------------------------------------------------------------------
    // Storage.
    // ----------------------------------------------------------------------
    logic [XLEN-1:0] regs [REG_COUNT];

    // x0 is never written, so it keeps its reset value of zero.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.en && (i_wr.addr != '0)) begin
            regs[i_wr.addr] <= i_wr.data;
        end
    end

    // ----------------------------------------------------------------------
    // Reads.
    // ----------------------------------------------------------------------
    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== logic/wb_cmd_slave.sv ====
// One access at a time; unmapped accesses and unknown opcodes are acked with no effect.
`default_nettype none
`timescale 1ns/1ps

module wb_cmd_slave
    import exec_pkg::*, bus_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  arstn,

    // Wishbone slave port.
    input  wire wb_req_t               i_wb,
    output wb_rsp_t                    o_wb,

    // Register file read ports.
    output logic      [REG_ADDR_W-1:0] o_raddr_a,
    output logic      [REG_ADDR_W-1:0] o_raddr_b,
    input  wire logic [XLEN-1:0]       i_rdata_a,
    input  wire logic [XLEN-1:0]       i_rdata_b,

    // To the units and the writeback.
    output issue_t                     o_issue,
    output reg_write_t                 o_load,
    input  wire logic                  i_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] rd_data_q;
    exec_cmd_t       cmd;
    logic            req;
    logic            is_reg;
    logic            is_cmd;
    logic            cmd_legal;

    // ----------------------------------------------------------------------
    // Decode.
    // ----------------------------------------------------------------------
    assign cmd       = exec_cmd_t'(i_wb.dat[$bits(exec_cmd_t)-1:0]);
    assign req       = i_wb.cyc && i_wb.stb;
    assign is_reg    = i_wb.adr < WB_ADR_W'(REG_COUNT);
    assign is_cmd    = i_wb.adr == ADR_CMD;
    assign cmd_legal = cmd.op <= OP_SRA;

    // Port a serves host reads as well as rs1.
    assign o_raddr_a = i_wb.we ? cmd.rs1 : i_wb.adr[REG_ADDR_W-1:0];
    assign o_raddr_b = cmd.rs2;

    // ----------------------------------------------------------------------
    // FSM.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state_q   <= ST_IDLE;
            rd_data_q <= '0;
            o_issue   <= '0;
            o_load    <= '0;
        end else begin
            // Issue and load are single-cycle pulses.
            o_issue.valid <= 1'b0;
            o_load.en     <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req) begin
                        if (!i_wb.we) begin
                            rd_data_q <= is_reg ? i_rdata_a : '0;
                            state_q   <= ST_ACK;
                        end else if (is_reg) begin
                            o_load  <= '{en: 1'b1, addr: i_wb.adr[REG_ADDR_W-1:0],
                                         data: i_wb.dat};
                            state_q <= ST_BUSY;
                        end else if (is_cmd && cmd_legal) begin
                            o_issue <= '{valid: 1'b1, op: cmd.op, rd: cmd.rd,
                                         a: i_rdata_a, b: i_rdata_b};
                            state_q <= ST_BUSY;
                        end else begin
                            state_q <= ST_ACK;
                        end
                    end
                end
                ST_BUSY: begin
                    if (i_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Reads ack from ST_ACK, writes ack on the writeback done.
    always_comb begin
        o_wb.ack = (state_q == ST_ACK) || ((state_q == ST_BUSY) && i_done);
        o_wb.dat = rd_data_q;
    end

endmodule

`default_nettype wire

// ==== logic/arith_unit.sv ====
// One-cycle ALU; results are 64-bit wraparound and compares return 0 or 1.
`default_nettype none
`timescale 1ns/1ps

module arith_unit
    import exec_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arstn,
    input  wire issue_t i_issue,
    output unit_result_t o_result
);

    logic [XLEN-1:0] value;
    logic            own_op;

    // ----------------------------------------------------------------------
    // Datapath.
    // ----------------------------------------------------------------------
    always_comb begin
        own_op = 1'b1;
        case (i_issue.op)
            OP_ADD:  value = i_issue.a + i_issue.b;
            OP_SUB:  value = i_issue.a - i_issue.b;
            OP_AND:  value = i_issue.a & i_issue.b;
            OP_OR:   value = i_issue.a | i_issue.b;
            OP_XOR:  value = i_issue.a ^ i_issue.b;
            OP_SLT: begin
                value = XLEN'($signed(i_issue.a) < $signed(i_issue.b));
            end
            OP_SLTU: begin
                value = XLEN'(i_issue.a < i_issue.b);
            end
            default: begin
                // Shifts belong to the other unit.
                value  = '0;
                own_op = 1'b0;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Output register.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_result <= '0;
        end else begin
            o_result.valid <= i_issue.valid && own_op;
            o_result.rd    <= i_issue.rd;
            o_result.value <= value;
        end
    end

endmodule

`default_nettype wire

// ==== logic/shift_unit.sv ====
// One-cycle shifter; only the low six bits of operand b give the amount.
`default_nettype none
`timescale 1ns/1ps

module shift_unit
    import exec_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arstn,
    input  wire issue_t  i_issue,
    output unit_result_t o_result
);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    value;
    logic               own_op;

    assign shamt = i_issue.b[SHAMT_W-1:0];

    // ----------------------------------------------------------------------
    // Datapath.
    // ----------------------------------------------------------------------
    always_comb begin
        own_op = 1'b1;
        case (i_issue.op)
            OP_SLL:  value = i_issue.a << shamt;
            OP_SRL:  value = i_issue.a >> shamt;
            // Sign bit fills from the left.
            OP_SRA:  value = $signed(i_issue.a) >>> shamt;
            default: begin
                value  = '0;
                own_op = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_result <= '0;
        end else begin
            o_result.valid <= i_issue.valid && own_op;
            o_result.rd    <= i_issue.rd;
            o_result.value <= value;
        end
    end

endmodule

`default_nettype wire

// ==== logic/writeback_merge.sv ====
// Assumes at most one source is valid per cycle; a host load wins any overlap.
`default_nettype none
`timescale 1ns/1ps

module writeback_merge
    import exec_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         arstn,

    // Write sources.
    input  wire unit_result_t i_arith,
    input  wire unit_result_t i_shift,
    input  wire reg_write_t   i_load,

    // Register file write port and completion.
    output reg_write_t        o_wr,
    output logic              o_done
);

    logic done_q;

    // ----------------------------------------------------------------------
    // Source select.
    // ----------------------------------------------------------------------
    always_comb begin
        if (i_load.en) begin
            o_wr = i_load;
        end else if (i_arith.valid) begin
            o_wr = '{en: 1'b1, addr: i_arith.rd, data: i_arith.value};
        end else if (i_shift.valid) begin
            o_wr = '{en: 1'b1, addr: i_shift.rd, data: i_shift.value};
        end else begin
            o_wr = '0;
        end
    end

    // ----------------------------------------------------------------------
    // Completion.
    // ----------------------------------------------------------------------

    // Done rises on the edge that commits the write.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= o_wr.en;
        end
    end

    assign o_done = done_q;

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
// Execute slice top; host access only through the Wishbone port, one access at a time.
`default_nettype none
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*, bus_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arstn,
    input  wire wb_req_t i_wb,
    output wb_rsp_t      o_wb
);

    // ----------------------------------------------------------------------
    // Internal nets.
    // ----------------------------------------------------------------------
    logic [REG_ADDR_W-1:0] raddr_a;
    logic [REG_ADDR_W-1:0] raddr_b;
    logic [XLEN-1:0]       rdata_a;
    logic [XLEN-1:0]       rdata_b;
    issue_t                issue;
    reg_write_t            load;
    reg_write_t            wr;
    unit_result_t          arith_res;
    unit_result_t          shift_res;
    logic                  done;

    // ----------------------------------------------------------------------
    // Blocks.
    // ----------------------------------------------------------------------
    wb_cmd_slave u_slave (
        .clk       (clk),
        .arstn     (arstn),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .o_raddr_a (raddr_a),
        .o_raddr_b (raddr_b),
        .i_rdata_a (rdata_a),
        .i_rdata_b (rdata_b),
        .o_issue   (issue),
        .o_load    (load),
        .i_done    (done)
    );

    register_file u_regs (
        .clk       (clk),
        .arstn     (arstn),
        .i_wr      (wr),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    arith_unit u_arith (
        .clk      (clk),
        .arstn    (arstn),
        .i_issue  (issue),
        .o_result (arith_res)
    );

    shift_unit u_shift (
        .clk      (clk),
        .arstn    (arstn),
        .i_issue  (issue),
        .o_result (shift_res)
    );

    writeback_merge u_wb_merge (
        .clk     (clk),
        .arstn   (arstn),
        .i_arith (arith_res),
        .i_shift (shift_res),
        .i_load  (load),
        .o_wr    (wr),
        .o_done  (done)
    );

endmodule

`default_nettype wire

// ==== testbench/exec_checker.sv ====
// Assumes one access at a time on the slave port; x0 is taken from the register file by hierarchy.
`default_nettype none
`timescale 1ns/1ps

module exec_checker
    import exec_pkg::*, bus_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arstn,
    input  wire wb_req_t         i_wb,
    input  wire wb_rsp_t         i_rsp,
    input  wire logic [XLEN-1:0] i_x0
);

    int unsigned violations = 0;
    logic        pending_q;
    logic        start;

    // Set while a strobe waits for its ack.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pending_q <= 1'b0;
        end else if (i_rsp.ack) begin
            pending_q <= 1'b0;
        end else if (i_wb.cyc && i_wb.stb) begin
            pending_q <= 1'b1;
        end
    end

    // First sampled cycle of a new strobe.
    assign start = i_wb.cyc && i_wb.stb && !pending_q;

    // ----------------------------------------------------------------------
    // Protocol and register properties.
    // ----------------------------------------------------------------------
    ack_with_strobe: assert property (@(posedge clk) disable iff (!arstn)
        $rose(i_rsp.ack) |-> (i_wb.cyc && i_wb.stb))
        else begin
            $error("ack rose without an active cyc and stb");
            violations++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!arstn)
        i_rsp.ack |=> !i_rsp.ack)
        else begin
            $error("ack stayed high for more than one cycle");
            violations++;
        end

    x0_stays_zero: assert property (@(posedge clk) disable iff (!arstn)
        i_x0 == '0)
        else begin
            $error("register x0 holds a nonzero value");
            violations++;
        end

    read_ack_next: assert property (@(posedge clk) disable iff (!arstn)
        (start && !i_wb.we) |=> i_rsp.ack)
        else begin
            $error("register read was not acknowledged one cycle after its strobe");
            violations++;
        end

endmodule

bind exec_top exec_checker u_checker (
    .clk   (clk),
    .arstn (arstn),
    .i_wb  (i_wb),
    .i_rsp (o_wb),
    .i_x0  (u_regs.regs[0])
);

`default_nettype wire

// ==== testbench/exec_tb.sv ====
// Reads testbench/exec_tests.txt relative to the project root; one Wishbone access at a time.
`default_nettype none
`timescale 1ns/1ps

module exec_tb
    import exec_pkg::*, bus_pkg::*;
();

    localparam string TEST_FILE    = "testbench/exec_tests.txt";
    localparam int    MAX_TESTS    = 64;
    localparam int    RESET_CYCLES = 16;
    localparam int    ACK_LIMIT    = 8;
    localparam int    READ_LATENCY = 1;
    localparam int    LOAD_LATENCY = 2;
    localparam int    CMD_LATENCY  = 3;

    logic    clk = 1'b0;
    logic    arstn;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // Test table, filled from the data file.
    string                 test_name [MAX_TESTS];
    string                 test_kind [MAX_TESTS];
    logic [3:0]            test_op   [MAX_TESTS];
    logic [REG_ADDR_W-1:0] test_rd   [MAX_TESTS];
    logic [REG_ADDR_W-1:0] test_rs1  [MAX_TESTS];
    logic [REG_ADDR_W-1:0] test_rs2  [MAX_TESTS];
    logic [XLEN-1:0]       test_data [MAX_TESTS];
    logic [XLEN-1:0]       test_exp  [MAX_TESTS];

    int          test_count   = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    logic        tests_loaded = 1'b0;
    logic [31:0] rng_state    = 32'd24;

    always #50 clk = ~clk;

    exec_top DUT (
        .clk   (clk),
        .arstn (arstn),
        .i_wb  (wb_req),
        .o_wb  (wb_rsp)
    );

    // ----------------------------------------------------------------------
    // Helpers.
    // ----------------------------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_tests();
        int                    fd;
        int                    fields;
        string                 line;
        string                 name;
        string                 kind;
        logic [3:0]            op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       exp;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" && test_count < MAX_TESTS) begin
                    fields = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                     name, kind, op, rd, rs1, rs2, data, exp);
                    if (fields == 8) begin
                        test_name[test_count] = name;
                        test_kind[test_count] = kind;
                        test_op[test_count]   = op;
                        test_rd[test_count]   = rd;
                        test_rs1[test_count]  = rs1;
                        test_rs2[test_count]  = rs2;
                        test_data[test_count] = data;
                        test_exp[test_count]  = exp;
                        test_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic insert_idle();
        rng_state = next_random(rng_state);
        repeat (rng_state[17:16]) @(negedge clk);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act == exp) else begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("MISMATCH %s ack latency: expected %0d, actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    // Called at a falling edge; returns at a falling edge.
    task automatic wb_access(input string name, input logic write,
                             input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] wdata,
                             input int exp_latency, output logic [WB_DAT_W-1:0] rdata);
        int cycles;
        cycles = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: wdata};
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_rsp.ack && cycles < ACK_LIMIT);
        rdata = wb_rsp.dat;
        assert (wb_rsp.ack) else begin
            $display("ERROR: %s got no acknowledge from the DUT within %0d cycles",
                     name, ACK_LIMIT);
            other_errors++;
        end
        if (wb_rsp.ack) begin
            check_latency(name, exp_latency, cycles);
        end
        // Request stays up through the ack edge.
        @(negedge clk);
        wb_req = '0;
        insert_idle();
    endtask

    task automatic read_reg(input string name, input logic [REG_ADDR_W-1:0] idx,
                            input logic [XLEN-1:0] exp);
        logic [WB_DAT_W-1:0] rdata;
        wb_access(name, 1'b0, WB_ADR_W'(idx), '0, READ_LATENCY, rdata);
        check_value(name, exp, rdata);
    endtask

    task automatic run_test(input int t);
        exec_cmd_t           cmd;
        logic [WB_DAT_W-1:0] rdata;
        if (test_kind[t] == "L") begin
            wb_access(test_name[t], 1'b1, WB_ADR_W'(test_rd[t]), test_data[t],
                      LOAD_LATENCY, rdata);
            read_reg(test_name[t], test_rd[t], test_exp[t]);
        end else if (test_kind[t] == "C") begin
            cmd = '{op: exec_op_e'(test_op[t]), rd: test_rd[t], rs1: test_rs1[t],
                    rs2: test_rs2[t]};
            wb_access(test_name[t], 1'b1, ADR_CMD, WB_DAT_W'(cmd), CMD_LATENCY, rdata);
            read_reg(test_name[t], test_rd[t], test_exp[t]);
        end else if (test_kind[t] == "R") begin
            read_reg(test_name[t], test_rd[t], test_exp[t]);
        end else begin
            $display("ERROR: test %s has an unknown kind %s", test_name[t], test_kind[t]);
            other_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence.
    // ----------------------------------------------------------------------
    initial begin
        wb_req = '0;
        arstn  = 1'b0;
        load_tests();
        if (test_count == 0) begin
            $display("ERROR: no tests could be read from %s", TEST_FILE);
            $display("TESTS FAILED");
            $finish;
        end else begin
            tests_loaded = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk);
            arstn = 1'b1;

            // Every register starts at zero.
            for (int i = 0; i < REG_COUNT; i++) begin
                read_reg($sformatf("reset_x%0d", i), REG_ADDR_W'(i), '0);
            end

            for (int t = 0; t < test_count; t++) begin
                run_test(t);
            end

            $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
                     mismatches, other_errors, DUT.u_checker.violations);
            if (mismatches == 0 && other_errors == 0 && DUT.u_checker.violations == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    // Ten cycles per test, the reset sweep counted as tests.
    initial begin
        wait (tests_loaded);
        repeat ((test_count + REG_COUNT) * 10 + RESET_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/exec_pkg.sv
logic/bus_pkg.sv
logic/register_file.sv
logic/wb_cmd_slave.sv
logic/arith_unit.sv
logic/shift_unit.sv
logic/writeback_merge.sv
logic/exec_top.sv
testbench/exec_checker.sv
testbench/exec_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module exec_tb -f build.f

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert --top-module exec_tb -f build.f -o exec_sim
	./obj_dir/exec_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/exec_tests.txt ====
# name kind op rd rs1 rs2 data expected; kind L = load, C = command, R = read
# op, registers, data and expected are hex; fields a kind does not use are 0
load_x0     L 0 00 00 00 0000000000001234 0000000000000000
load_x1     L 0 01 00 00 0000000000000005 0000000000000005
load_x2     L 0 02 00 00 fffffffffffffffd fffffffffffffffd
load_x3     L 0 03 00 00 7fffffffffffffff 7fffffffffffffff
load_x4     L 0 04 00 00 0000000000000001 0000000000000001
load_x5     L 0 05 00 00 8000000000000000 8000000000000000
load_x6     L 0 06 00 00 00000000000000c4 00000000000000c4
load_x7     L 0 07 00 00 f0f0f0f0f0f0f0f0 f0f0f0f0f0f0f0f0
load_x8     L 0 08 00 00 0ff00ff00ff00ff0 0ff00ff00ff00ff0
add_wrap    C 0 0a 03 04 0000000000000000 8000000000000000
add_mixed   C 0 0b 01 02 0000000000000000 0000000000000002
sub_wrap    C 1 0c 05 04 0000000000000000 7fffffffffffffff
sub_neg     C 1 0d 04 01 0000000000000000 fffffffffffffffc
and_mask    C 2 0e 07 08 0000000000000000 00f000f000f000f0
or_mask     C 3 0f 07 08 0000000000000000 fff0fff0fff0fff0
xor_mask    C 4 10 07 08 0000000000000000 ff00ff00ff00ff00
slt_neg     C 5 11 02 01 0000000000000000 0000000000000001
sltu_neg    C 6 12 02 01 0000000000000000 0000000000000000
sltu_pos    C 6 13 01 02 0000000000000000 0000000000000001
sll_low6    C 7 14 01 06 0000000000000000 0000000000000050
srl_low6    C 8 15 05 06 0000000000000000 0800000000000000
sra_low6    C 9 16 05 06 0000000000000000 f800000000000000
sra_neg     C 9 17 02 04 0000000000000000 fffffffffffffffe
cmd_to_x0   C 0 00 01 01 0000000000000000 0000000000000000
rd_is_rs    C 0 01 01 01 0000000000000000 000000000000000a
read_x1     R 0 01 00 00 0000000000000000 000000000000000a
read_x0     R 0 00 00 00 0000000000000000 0000000000000000
